/* Bender.yml */
package:
  name: async_fifo

sources:
  - rtl/afifo_pkg.sv
  - rtl/afifo_dpram.sv
  - rtl/afifo_gray_sync.sv
  - rtl/afifo_wr_ctrl.sv
  - rtl/afifo_rd_ctrl.sv
  - rtl/async_fifo.sv
  - target: test
    files:
      - tests/async_fifo_assert.sv
      - tests/async_fifo_tb.sv

/* rtl/afifo_dpram.sv */
`timescale 1ns/100ps

module afifo_dpram
  import afifo_pkg::*;
(
  input  logic  wr_clk,
  input  logic  wr_en,
  input  addr_t wr_addr,
  input  data_t wr_data,
  input  logic  rd_clk,
  input  logic  rd_rst_n,
  input  logic  rd_en,
  input  addr_t rd_addr,
  output data_t rd_data
);

  data_t mem [FIFO_DEPTH];

  // Write port, clocked in the write domain.
  always_ff @(posedge wr_clk) begin
    if (wr_en) begin
      mem[wr_addr] <= wr_data;
    end
  end

  // The read port loads only on an accepted read, so rd_data holds the
  // last word handed out while the reader is idle or the FIFO is empty.
  // The word at rd_addr was written several write-clock edges before its
  // pointer could reach this domain, so it is stable when sampled here.
  always_ff @(posedge rd_clk or negedge rd_rst_n) begin
    if (!rd_rst_n) begin
      rd_data <= '0;
    end else if (rd_en) begin
      rd_data <= mem[rd_addr];
    end
  end

endmodule

/* rtl/afifo_gray_sync.sv */
`timescale 1ns/100ps

module afifo_gray_sync
  import afifo_pkg::*;
(
  input  logic dst_clk,
  input  logic dst_rst_n,
  input  ptr_t gray_in,
  output ptr_t ptr_bin
);

  ptr_t gray_meta;
  ptr_t gray_sync;

  // gray_in comes from a register in the other domain and changes at most
  // one bit per source edge, so a late capture only lags by one count.
  always_ff @(posedge dst_clk or negedge dst_rst_n) begin
    if (!dst_rst_n) begin
      gray_meta <= '0;
      gray_sync <= '0;
    end else begin
      gray_meta <= gray_in;
      gray_sync <= gray_meta;
    end
  end

  // Back to binary so the controllers can subtract pointers directly.
  assign ptr_bin = gray2bin(gray_sync);

endmodule

/* rtl/afifo_pkg.sv */
package afifo_pkg;

  // Storage geometry of the FIFO.
  localparam int unsigned DATA_WIDTH = 8;
  localparam int unsigned FIFO_DEPTH = 16;
  localparam int unsigned ADDR_WIDTH = $clog2(FIFO_DEPTH);

  // One extra bit tells a full RAM from an empty one.
  localparam int unsigned PTR_WIDTH  = ADDR_WIDTH + 1;

  // Flag thresholds are counted in stored words.
  localparam int unsigned FIFO_AFULL  = FIFO_DEPTH - 1;
  localparam int unsigned FIFO_AEMPTY = 1;

  typedef logic [DATA_WIDTH-1:0] data_t;
  typedef logic [ADDR_WIDTH-1:0] addr_t;
  typedef logic [PTR_WIDTH-1:0]  ptr_t;

  // Adjacent binary counts map to Gray codes that differ in a single bit.
  function automatic ptr_t bin2gray(input ptr_t bin);
    return bin ^ (bin >> 1);
  endfunction

  function automatic ptr_t gray2bin(input ptr_t gray);
    ptr_t bin;
    bin[PTR_WIDTH-1] = gray[PTR_WIDTH-1];
    for (int i = PTR_WIDTH - 2; i >= 0; i--) begin
      bin[i] = bin[i+1] ^ gray[i];
    end
    return bin;
  endfunction

endpackage

/* rtl/afifo_rd_ctrl.sv */
`timescale 1ns/100ps

module afifo_rd_ctrl
  import afifo_pkg::*;
(
  input  logic  rd_clk,
  input  logic  rd_rst_n,
  input  logic  rd_en,
  input  ptr_t  wr_ptr_sync,
  output logic  rd_accept,
  output addr_t rd_addr,
  output ptr_t  rd_gray,
  output logic  empty,
  output logic  aempty
);

  ptr_t rd_ptr;
  ptr_t rd_ptr_next;
  ptr_t fill_next;
  logic empty_next;
  logic aempty_next;

  // A read offered while empty pops nothing and leaves rd_data alone.
  assign rd_accept = rd_en && !empty;

  // The current pointer addresses the oldest word still held.
  assign rd_addr = rd_ptr[ADDR_WIDTH-1:0];

  always_comb begin
    rd_ptr_next = rd_ptr;
    if (rd_accept) begin
      rd_ptr_next = rd_ptr + ptr_t'(1);
    end
  end

  // The write pointer seen here lags the writer, so this count is never
  // more than the true fill level and the flags err toward set.
  assign fill_next   = wr_ptr_sync - rd_ptr_next;
  assign empty_next  = (fill_next == '0);
  assign aempty_next = (fill_next <= ptr_t'(FIFO_AEMPTY));

  always_ff @(posedge rd_clk or negedge rd_rst_n) begin
    if (!rd_rst_n) begin
      rd_ptr <= '0;
    end else begin
      rd_ptr <= rd_ptr_next;
    end
  end

  // Registered Gray copy for the crossing into the write domain.
  always_ff @(posedge rd_clk or negedge rd_rst_n) begin
    if (!rd_rst_n) begin
      rd_gray <= '0;
    end else begin
      rd_gray <= bin2gray(rd_ptr_next);
    end
  end

  // The FIFO comes out of reset empty, so both flags reset high.
  // empty rises on the same edge as the read that takes the last word.
  always_ff @(posedge rd_clk or negedge rd_rst_n) begin
    if (!rd_rst_n) begin
      empty  <= 1'b1;
      aempty <= 1'b1;
    end else begin
      empty  <= empty_next;
      aempty <= aempty_next;
    end
  end

endmodule

/* rtl/afifo_wr_ctrl.sv */
`timescale 1ns/100ps

module afifo_wr_ctrl
  import afifo_pkg::*;
(
  input  logic  wr_clk,
  input  logic  wr_rst_n,
  input  logic  wr_en,
  input  ptr_t  rd_ptr_sync,
  output logic  wr_accept,
  output addr_t wr_addr,
  output ptr_t  wr_gray,
  output logic  full,
  output logic  afull
);

  ptr_t wr_ptr;
  ptr_t wr_ptr_next;
  ptr_t fill_next;
  logic full_next;
  logic afull_next;

  // A write offered while full is dropped here and never reaches the RAM.
  assign wr_accept = wr_en && !full;

  // The RAM is addressed by the pointer without its wrap bit.
  assign wr_addr = wr_ptr[ADDR_WIDTH-1:0];

  always_comb begin
    wr_ptr_next = wr_ptr;
    if (wr_accept) begin
      wr_ptr_next = wr_ptr + ptr_t'(1);
    end
  end

  // The read pointer seen here is old, so this count can only be too high.
  // That keeps both flags pessimistic and never late to set.
  assign fill_next  = wr_ptr_next - rd_ptr_sync;
  assign full_next  = (fill_next == ptr_t'(FIFO_DEPTH));
  assign afull_next = (fill_next >= ptr_t'(FIFO_AFULL));

  always_ff @(posedge wr_clk or negedge wr_rst_n) begin
    if (!wr_rst_n) begin
      wr_ptr <= '0;
    end else begin
      wr_ptr <= wr_ptr_next;
    end
  end

  // The Gray image is registered so the crossing sees a glitch-free value.
  always_ff @(posedge wr_clk or negedge wr_rst_n) begin
    if (!wr_rst_n) begin
      wr_gray <= '0;
    end else begin
      wr_gray <= bin2gray(wr_ptr_next);
    end
  end

  // Flags are taken from the next pointer, so full rises on the same edge
  // that stores the word filling the last free slot.
  always_ff @(posedge wr_clk or negedge wr_rst_n) begin
    if (!wr_rst_n) begin
      full  <= 1'b0;
      afull <= 1'b0;
    end else begin
      full  <= full_next;
      afull <= afull_next;
    end
  end

endmodule

/* rtl/async_fifo.sv */
`timescale 1ns/100ps

module async_fifo
  import afifo_pkg::*;
(
  input  logic  wr_clk,
  input  logic  wr_rst_n,
  input  logic  wr_en,
  input  data_t wr_data,
  input  logic  rd_clk,
  input  logic  rd_rst_n,
  input  logic  rd_en,
  output data_t rd_data,
  output logic  full,
  output logic  afull,
  output logic  empty,
  output logic  aempty
);

  logic  wr_accept;
  addr_t wr_addr;
  ptr_t  wr_gray;
  ptr_t  rd_ptr_sync;

  logic  rd_accept;
  addr_t rd_addr;
  ptr_t  rd_gray;
  ptr_t  wr_ptr_sync;

  afifo_wr_ctrl wr_ctrl (
    .wr_clk      (wr_clk),
    .wr_rst_n    (wr_rst_n),
    .wr_en       (wr_en),
    .rd_ptr_sync (rd_ptr_sync),
    .wr_accept   (wr_accept),
    .wr_addr     (wr_addr),
    .wr_gray     (wr_gray),
    .full        (full),
    .afull       (afull)
  );

  afifo_rd_ctrl rd_ctrl (
    .rd_clk      (rd_clk),
    .rd_rst_n    (rd_rst_n),
    .rd_en       (rd_en),
    .wr_ptr_sync (wr_ptr_sync),
    .rd_accept   (rd_accept),
    .rd_addr     (rd_addr),
    .rd_gray     (rd_gray),
    .empty       (empty),
    .aempty      (aempty)
  );

  afifo_dpram ram (
    .wr_clk   (wr_clk),
    .wr_en    (wr_accept),
    .wr_addr  (wr_addr),
    .wr_data  (wr_data),
    .rd_clk   (rd_clk),
    .rd_rst_n (rd_rst_n),
    .rd_en    (rd_accept),
    .rd_addr  (rd_addr),
    .rd_data  (rd_data)
  );

  // Only Gray pointers cross between the two clock domains.
  afifo_gray_sync wr_to_rd_sync (
    .dst_clk   (rd_clk),
    .dst_rst_n (rd_rst_n),
    .gray_in   (wr_gray),
    .ptr_bin   (wr_ptr_sync)
  );

  afifo_gray_sync rd_to_wr_sync (
    .dst_clk   (wr_clk),
    .dst_rst_n (wr_rst_n),
    .gray_in   (rd_gray),
    .ptr_bin   (rd_ptr_sync)
  );

endmodule

/* sim.f */
rtl/afifo_pkg.sv
rtl/afifo_dpram.sv
rtl/afifo_gray_sync.sv
rtl/afifo_wr_ctrl.sv
rtl/afifo_rd_ctrl.sv
rtl/async_fifo.sv
tests/async_fifo_assert.sv
tests/async_fifo_tb.sv

/* tests/async_fifo_assert.sv */
`timescale 1ns/100ps

module async_fifo_sva
  import afifo_pkg::*;
(
  input logic  wr_clk,
  input logic  wr_rst_n,
  input logic  rd_clk,
  input logic  rd_rst_n,
  input logic  full,
  input logic  afull,
  input logic  empty,
  input logic  aempty,
  input logic  rd_accept,
  input data_t rd_data
);

  full_implies_afull: assert property (
    @(posedge wr_clk) disable iff (!wr_rst_n) full |-> afull
  ) else $error("full is set while afull is clear");

  empty_implies_aempty: assert property (
    @(posedge rd_clk) disable iff (!rd_rst_n) empty |-> aempty
  ) else $error("empty is set while aempty is clear");

  // Full changes only on write edges, which never meet a read edge here.
  never_full_and_empty: assert property (
    @(posedge rd_clk) disable iff (!rd_rst_n) !(full && empty)
  ) else $error("full and empty are set together");

  rd_data_holds: assert property (
    @(posedge rd_clk) disable iff (!rd_rst_n) !rd_accept |=> $stable(rd_data)
  ) else $error("rd_data changed without an accepted read");

  empty_after_reset: assert property (
    @(posedge rd_clk) $rose(rd_rst_n) |-> empty
  ) else $error("empty is clear on leaving reset");

  not_full_after_reset: assert property (
    @(posedge wr_clk) $rose(wr_rst_n) |-> !full
  ) else $error("full is set on leaving reset");

endmodule

bind async_fifo async_fifo_sva sva (
  .wr_clk    (wr_clk),
  .wr_rst_n  (wr_rst_n),
  .rd_clk    (rd_clk),
  .rd_rst_n  (rd_rst_n),
  .full      (full),
  .afull     (afull),
  .empty     (empty),
  .aempty    (aempty),
  .rd_accept (rd_accept),
  .rd_data   (rd_data)
);

/* tests/async_fifo_tb.sv */
`timescale 1ns/100ps

module async_fifo_tb
  import afifo_pkg::*;
();

  // One row per phase. Rows with conc set count accepted operations under
  // random enables on both sides. Other rows count offers, with the enable
  // held high, writes first and reads after the writes have settled.
  typedef struct packed {
    int   n_wr;
    int   n_rd;
    logic conc;
    logic exp_full;
    logic exp_afull;
    logic exp_empty;
    logic exp_aempty;
  } phase_t;

  localparam int NUM_PHASES = 12;

  phase_t phases [NUM_PHASES] = '{
    '{1,   0,   1'b0, 1'b0, 1'b0, 1'b0, 1'b1},
    '{1,   0,   1'b0, 1'b0, 1'b0, 1'b0, 1'b0},
    '{12,  0,   1'b0, 1'b0, 1'b0, 1'b0, 1'b0},
    '{1,   0,   1'b0, 1'b0, 1'b1, 1'b0, 1'b0},
    '{1,   0,   1'b0, 1'b1, 1'b1, 1'b0, 1'b0},
    '{0,   16,  1'b0, 1'b0, 1'b0, 1'b1, 1'b1},
    '{20,  0,   1'b0, 1'b1, 1'b1, 1'b0, 1'b0},
    '{0,   16,  1'b0, 1'b0, 1'b0, 1'b1, 1'b1},
    '{0,   4,   1'b0, 1'b0, 1'b0, 1'b1, 1'b1},
    '{10,  10,  1'b0, 1'b0, 1'b0, 1'b1, 1'b1},
    '{150, 150, 1'b1, 1'b0, 1'b0, 1'b1, 1'b1},
    '{16,  16,  1'b0, 1'b0, 1'b0, 1'b1, 1'b1}
  };

  logic  wr_clk;
  logic  wr_rst_n;
  logic  wr_en;
  data_t wr_data;
  logic  rd_clk;
  logic  rd_rst_n;
  logic  rd_en;
  data_t rd_data;
  logic  full;
  logic  afull;
  logic  empty;
  logic  aempty;

  data_t       model_q [$];
  data_t       exp_rd;
  logic [31:0] wr_lcg_state;
  logic [31:0] rd_lcg_state;
  int          error_count;
  int          cycle_count;
  int          cycle_limit;

  async_fifo uut (
    .wr_clk   (wr_clk),
    .wr_rst_n (wr_rst_n),
    .wr_en    (wr_en),
    .wr_data  (wr_data),
    .rd_clk   (rd_clk),
    .rd_rst_n (rd_rst_n),
    .rd_en    (rd_en),
    .rd_data  (rd_data),
    .full     (full),
    .afull    (afull),
    .empty    (empty),
    .aempty   (aempty)
  );

  initial begin
    rd_clk = 1'b0;
    forever #50 rd_clk = ~rd_clk;
  end

  initial begin
    wr_clk = 1'b0;
    forever #35 wr_clk = ~wr_clk;
  end

  // Writer and reader each step their own LCG state.
  function automatic logic [31:0] lcg_next(input logic [31:0] state);
    return state * 32'd1103515245 + 32'd12345;
  endfunction

  function automatic int total_ops();
    int sum;
    sum = 0;
    for (int i = 0; i < NUM_PHASES; i++) begin
      sum += phases[i].n_wr + phases[i].n_rd;
    end
    return sum;
  endfunction

  task automatic stop_with_failure();
    $display("TEST FAILED");
    $fatal(1, "simulation stopped after a failed check");
  endtask

  task automatic check_data(input string name, input data_t expected, input data_t actual);
    if (actual !== expected) begin
      $display("mismatch at %0t: %s expected %02h actual %02h", $time, name, expected, actual);
      stop_with_failure();
    end
  endtask

  task automatic check_flag(input string name, input logic expected, input logic actual);
    if (actual !== expected) begin
      $display("mismatch at %0t: %s expected %b actual %b", $time, name, expected, actual);
      stop_with_failure();
    end
  endtask

  // A full model queue means the DUT holds 16 words too, so full must be set.
  task automatic run_writes(input int count, input logic conc);
    int          done;
    logic [31:0] r;
    logic        take;
    done = 0;
    while (done < count) begin
      @(negedge wr_clk);
      wr_lcg_state = lcg_next(wr_lcg_state);
      r = wr_lcg_state;
      if (conc) begin
        if (model_q.size() == FIFO_DEPTH) begin
          check_flag("full", 1'b1, full);
        end
        wr_en = r[12];
        take  = r[12] && !full;
      end else begin
        check_flag("full", model_q.size() == FIFO_DEPTH, full);
        wr_en = 1'b1;
        take  = (model_q.size() < FIFO_DEPTH);
      end
      wr_data = r[23:16];
      if (take) begin
        model_q.push_back(r[23:16]);
      end
      if (!conc || take) begin
        done++;
      end
    end
    @(negedge wr_clk);
    wr_en = 1'b0;
  endtask

  // rd_data is checked one cycle after each offer and must hold on a refused read.
  task automatic run_reads(input int count, input logic conc);
    int          done;
    logic [31:0] r;
    logic        take;
    done = 0;
    while (done < count) begin
      @(negedge rd_clk);
      check_data("rd_data", exp_rd, rd_data);
      rd_lcg_state = lcg_next(rd_lcg_state);
      r = rd_lcg_state;
      if (conc) begin
        if (model_q.size() == 0) begin
          check_flag("empty", 1'b1, empty);
        end
        rd_en = r[9];
        take  = r[9] && !empty;
      end else begin
        check_flag("empty", model_q.size() == 0, empty);
        rd_en = 1'b1;
        take  = (model_q.size() != 0);
      end
      if (take) begin
        exp_rd = model_q.pop_front();
      end
      if (!conc || take) begin
        done++;
      end
    end
    @(negedge rd_clk);
    rd_en = 1'b0;
    check_data("rd_data", exp_rd, rd_data);
  endtask

  task automatic wait_idle();
    fork
      repeat (4) @(negedge wr_clk);
      repeat (4) @(negedge rd_clk);
    join
  endtask

  // Each side's flags are sampled on that side's own falling edge.
  task automatic check_settled(input phase_t p);
    fork
      begin
        repeat (4) @(negedge wr_clk);
        check_flag("full", p.exp_full, full);
        check_flag("afull", p.exp_afull, afull);
      end
      begin
        repeat (4) @(negedge rd_clk);
        check_flag("empty", p.exp_empty, empty);
        check_flag("aempty", p.exp_aempty, aempty);
      end
    join
  endtask

  initial begin
    cycle_limit = 60 * total_ops() + 200;
    cycle_count = 0;
    while (cycle_count < cycle_limit) begin
      @(posedge rd_clk);
      cycle_count++;
    end
    $display("timeout: the test did not finish within %0d read clock cycles", cycle_limit);
    stop_with_failure();
  end

  initial begin
    wr_rst_n     = 1'b0;
    rd_rst_n     = 1'b0;
    wr_en        = 1'b0;
    wr_data      = '0;
    rd_en        = 1'b0;
    wr_lcg_state = 32'd94;
    rd_lcg_state = 32'd94;
    error_count  = 0;
    exp_rd       = '0;
    // Reset spans five full read clock periods from time zero.
    repeat (5) @(posedge rd_clk);
    @(negedge rd_clk);
    wr_rst_n = 1'b1;
    rd_rst_n = 1'b1;

    @(negedge wr_clk);
    check_flag("full", 1'b0, full);
    check_flag("afull", 1'b0, afull);
    @(negedge rd_clk);
    check_flag("empty", 1'b1, empty);
    check_flag("aempty", 1'b1, aempty);
    check_data("rd_data", '0, rd_data);

    for (int i = 0; i < NUM_PHASES; i++) begin
      if (phases[i].conc) begin
        fork
          run_writes(phases[i].n_wr, 1'b1);
          run_reads(phases[i].n_rd, 1'b1);
        join
      end else begin
        if (phases[i].n_wr > 0) begin
          run_writes(phases[i].n_wr, 1'b0);
        end
        if (phases[i].n_wr > 0 && phases[i].n_rd > 0) begin
          wait_idle();
        end
        if (phases[i].n_rd > 0) begin
          run_reads(phases[i].n_rd, 1'b0);
        end
      end
      check_settled(phases[i]);
    end

    if (model_q.size() != 0) begin
      $display("model queue still holds %0d words that were never read", model_q.size());
      error_count++;
    end
    if (error_count == 0) begin
      $display("TEST PASSED");
      $finish;
    end else begin
      stop_with_failure();
    end
  end

endmodule
